// File: rtl/cpu_pkg.sv
/* cpu package
   opcodes, alu and bypass codes, and the payloads carried between pipeline stages */
package cpu_pkg;

    localparam int xlen = 32;

    // rv32i major opcodes in the subset
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_opimm  = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_pass_b = 3'd4
    } alu_op_t;

    // where a consumer takes its operand from
    typedef enum logic [1:0] {
        bp_none = 2'd0,
        bp_mem  = 2'd1,
        bp_wb   = 2'd2
    } bp_sel_t;

    typedef struct packed {
        logic [xlen-1:0] instr;
        logic [xlen-1:0] pc;
    } if_id_t;

    typedef struct packed {
        logic [xlen-1:0] rd1;
        logic [xlen-1:0] rd2;
        logic [xlen-1:0] imm;
        logic [4:0]      ra1;
        logic [4:0]      ra2;
        logic [4:0]      wa;
        alu_op_t         alu_op;
        logic            src_b_imm;
        logic            we_rf;
        logic            we_dm;
        logic            rf_src;     // write-back from data memory (load)
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0] result;
        logic [xlen-1:0] store_data;
        logic [4:0]      wa;
        logic            we_rf;
        logic            we_dm;
        logic            rf_src;
    } ex_mem_t;

    typedef struct packed {
        logic [xlen-1:0] result;
        logic [4:0]      wa;
        logic            we_rf;
        logic            rf_src;
    } mem_wb_t;

endpackage : cpu_pkg

// File: rtl/hazard_if.sv
/* hazard interface
   register addresses and write enables in, bypass selects and stall controls out */
`timescale 1ns/100ps

interface hazard_if;
    import cpu_pkg::*;

    logic [4:0] ra1_id, ra2_id;
    logic [4:0] ra1_ex, ra2_ex;
    logic [4:0] wa_ex, wa_mem, wa_wb;
    logic       we_rf_ex, we_rf_mem, we_rf_wb;
    logic       load_ex, load_mem;
    logic       branch_id;
    bp_sel_t    rd1_bp, rd2_bp;     // execute operand selects
    bp_sel_t    cmp1_bp, cmp2_bp;   // beq compare selects
    logic       stall;
    logic       flush_ex;

    modport pipe (
        output ra1_id, ra2_id, ra1_ex, ra2_ex, wa_ex, wa_mem, wa_wb,
        output we_rf_ex, we_rf_mem, we_rf_wb, load_ex, load_mem, branch_id,
        input  rd1_bp, rd2_bp, cmp1_bp, cmp2_bp, stall, flush_ex
    );

    modport unit (
        input  ra1_id, ra2_id, ra1_ex, ra2_ex, wa_ex, wa_mem, wa_wb,
        input  we_rf_ex, we_rf_mem, we_rf_wb, load_ex, load_mem, branch_id,
        output rd1_bp, rd2_bp, cmp1_bp, cmp2_bp, stall, flush_ex
    );

endinterface : hazard_if

// File: rtl/pipe_reg.sv
/* pipeline stage register, generic over its payload type */
`timescale 1ns/100ps

module pipe_reg
#(
    parameter type payload_t = logic
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     en,
    input  logic     clr,
    input  payload_t d,
    output payload_t q
);

    // an all-zero payload is a bubble
    always_ff @(posedge clk)
    begin
        if (reset || clr)
            q <= '0;
        else if (en)
            q <= d;
    end

endmodule : pipe_reg

// File: rtl/fetch_unit.sv
/* fetch unit
   program counter for fetch 1 and its copy aligned with the instruction memory latency */
`timescale 1ns/100ps

module fetch_unit
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     stall,
    input  logic                     branch_taken,
    input  logic [cpu_pkg::xlen-1:0] branch_target,
    output logic [cpu_pkg::xlen-1:0] pc_if1,
    output logic [cpu_pkg::xlen-1:0] pc_if2
);

    logic [cpu_pkg::xlen-1:0] pc_seq;   // next sequential fetch address

    // on stall the fetch 2 word is read again so it is still there next cycle
    assign pc_if1 = branch_taken ? branch_target :
                    stall        ? pc_if2        : pc_seq;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc_seq <= '0;
            pc_if2 <= '0;
        end
        else if (!stall)
        begin
            pc_seq <= pc_if1 + 'd4;
            pc_if2 <= pc_if1;
        end
    end

endmodule : fetch_unit

// File: rtl/reg_file.sv
/* register file, 32 x 32
   two read ports, one write port and a debug read port, write-first */
`timescale 1ns/100ps

module reg_file
(
    input  logic                     clk,
    input  logic [4:0]               ra1,
    input  logic [4:0]               ra2,
    input  logic [4:0]               wa3,
    input  logic [4:0]               ra0,
    input  logic [cpu_pkg::xlen-1:0] wd3,
    input  logic                     we3,
    output logic [cpu_pkg::xlen-1:0] rd1,
    output logic [cpu_pkg::xlen-1:0] rd2,
    output logic [cpu_pkg::xlen-1:0] rd0
);

    logic [cpu_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk)
    begin
        if (we3 && wa3 != 5'd0)
            regs[wa3] <= wd3;
    end

    // x0 first, then same-cycle write, then the array
    assign rd1 = (ra1 == 5'd0) ? '0 : (we3 && ra1 == wa3) ? wd3 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : (we3 && ra2 == wa3) ? wd3 : regs[ra2];
    assign rd0 = (ra0 == 5'd0) ? '0 : (we3 && ra0 == wa3) ? wd3 : regs[ra0];

endmodule : reg_file

// File: rtl/decode_unit.sv
/* decode unit
   field and immediate decode, control generation and the beq compare */
`timescale 1ns/100ps

module decode_unit
(
    input  logic [cpu_pkg::xlen-1:0] instr,
    input  logic [cpu_pkg::xlen-1:0] pc,
    input  logic [cpu_pkg::xlen-1:0] cmp1,
    input  logic [cpu_pkg::xlen-1:0] cmp2,
    output cpu_pkg::id_ex_t          ctrl,
    output logic                     branch,
    output logic                     branch_taken,
    output logic [cpu_pkg::xlen-1:0] branch_target
);
    import cpu_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            funct7_b5;
    logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];     // selects sub

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    // unused source fields stay zero so they never raise a hazard
    always_comb
    begin
        ctrl        = '0;
        ctrl.alu_op = alu_add;
        case (opcode)
            op_op:
            begin
                ctrl.ra1   = instr[19:15];
                ctrl.ra2   = instr[24:20];
                ctrl.wa    = instr[11:7];
                ctrl.we_rf = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = funct7_b5 ? alu_sub : alu_add;
                    3'b111:  ctrl.alu_op = alu_and;
                    3'b110:  ctrl.alu_op = alu_or;
                    default: ctrl.we_rf = 1'b0;  // outside the subset
                endcase
            end
            op_opimm:
            begin
                ctrl.ra1       = instr[19:15];
                ctrl.wa        = instr[11:7];
                ctrl.imm       = imm_i;
                ctrl.src_b_imm = 1'b1;
                ctrl.we_rf     = (funct3 == 3'b000);  // addi only
            end
            op_lui:
            begin
                ctrl.wa        = instr[11:7];
                ctrl.imm       = imm_u;
                ctrl.src_b_imm = 1'b1;
                ctrl.alu_op    = alu_pass_b;
                ctrl.we_rf     = 1'b1;
            end
            op_load:
            begin
                ctrl.ra1       = instr[19:15];
                ctrl.wa        = instr[11:7];
                ctrl.imm       = imm_i;
                ctrl.src_b_imm = 1'b1;
                ctrl.we_rf     = (funct3 == 3'b010);
                ctrl.rf_src    = (funct3 == 3'b010);
            end
            op_store:
            begin
                ctrl.ra1       = instr[19:15];
                ctrl.ra2       = instr[24:20];
                ctrl.imm       = imm_s;
                ctrl.src_b_imm = 1'b1;
                ctrl.we_dm     = (funct3 == 3'b010);  // sw only
            end
            op_branch:
            begin
                ctrl.ra1 = instr[19:15];
                ctrl.ra2 = instr[24:20];
            end
            default: ;
        endcase
    end

    assign branch        = (opcode == op_branch) && (funct3 == 3'b000);
    assign branch_taken  = branch && (cmp1 == cmp2);
    assign branch_target = pc + imm_b;

endmodule : decode_unit

// File: rtl/exec_unit.sv
/* execute unit
   alu with register or immediate second operand */
`timescale 1ns/100ps

module exec_unit
(
    input  logic [cpu_pkg::xlen-1:0] a,
    input  logic [cpu_pkg::xlen-1:0] b,
    input  logic [cpu_pkg::xlen-1:0] imm,
    input  logic                     src_b_imm,
    input  cpu_pkg::alu_op_t         alu_op,
    output logic [cpu_pkg::xlen-1:0] result
);
    import cpu_pkg::*;

    logic [xlen-1:0] op_b;

    assign op_b = src_b_imm ? imm : b;

    always_comb
    begin
        case (alu_op)
            alu_add:    result = a + op_b;
            alu_sub:    result = a - op_b;
            alu_and:    result = a & op_b;
            alu_or:     result = a | op_b;
            alu_pass_b: result = op_b;    // lui
            default:    result = a + op_b;
        endcase
    end

endmodule : exec_unit

// File: rtl/hazard_unit.sv
/* hazard unit
   bypass selects for execute and the beq compare, load-use and branch stalls */
`timescale 1ns/100ps

module hazard_unit
(
    hazard_if.unit hz
);
    import cpu_pkg::*;

    logic load_use;
    logic branch_hold;

    // memory stage wins over write-back, x0 is never forwarded
    function automatic bp_sel_t fwd_sel(input logic [4:0] ra, input logic [4:0] wa_m,
                                        input logic we_m, input logic [4:0] wa_w,
                                        input logic we_w);
        bp_sel_t sel;
        sel = bp_none;
        if (ra != 5'd0 && we_m && wa_m == ra)
            sel = bp_mem;
        else if (ra != 5'd0 && we_w && wa_w == ra)
            sel = bp_wb;
        return sel;
    endfunction

    always_comb
    begin
        hz.rd1_bp = fwd_sel(hz.ra1_ex, hz.wa_mem, hz.we_rf_mem, hz.wa_wb, hz.we_rf_wb);
        hz.rd2_bp = fwd_sel(hz.ra2_ex, hz.wa_mem, hz.we_rf_mem, hz.wa_wb, hz.we_rf_wb);
    end

    // compare only takes the memory stage, write-back comes through the register file
    assign hz.cmp1_bp = (hz.ra1_id != 5'd0 && hz.we_rf_mem && hz.wa_mem == hz.ra1_id) ?
                        bp_mem : bp_none;
    assign hz.cmp2_bp = (hz.ra2_id != 5'd0 && hz.we_rf_mem && hz.wa_mem == hz.ra2_id) ?
                        bp_mem : bp_none;

    assign load_use = hz.load_ex && hz.wa_ex != 5'd0 &&
                      (hz.wa_ex == hz.ra1_id || hz.wa_ex == hz.ra2_id);

    // beq waits for any producer in execute and for a load still in memory
    assign branch_hold = hz.branch_id &&
        ((hz.we_rf_ex && hz.wa_ex != 5'd0 &&
          (hz.wa_ex == hz.ra1_id || hz.wa_ex == hz.ra2_id)) ||
         (hz.load_mem && hz.wa_mem != 5'd0 &&
          (hz.wa_mem == hz.ra1_id || hz.wa_mem == hz.ra2_id)));

    assign hz.stall    = load_use || branch_hold;
    assign hz.flush_ex = hz.stall;    // bubble into execute

endmodule : hazard_unit

// File: rtl/cpu_core.sv
/* five-stage rv32i subset core
   fetch, decode, execute, memory and write-back with bypassing and a decode-stage beq */
`timescale 1ns/100ps

module cpu_core
(
    input  logic                     clk,
    input  logic                     reset,
    output logic [cpu_pkg::xlen-1:0] instr_addr,
    input  logic [cpu_pkg::xlen-1:0] instr,
    output logic [cpu_pkg::xlen-1:0] addr_dm,
    output logic [cpu_pkg::xlen-1:0] wd_dm,
    output logic                     we_dm,
    input  logic [cpu_pkg::xlen-1:0] rd_dm,
    input  logic [4:0]               reg_addr,
    output logic [cpu_pkg::xlen-1:0] reg_data
);
    import cpu_pkg::*;

    if_id_t  if_id_d, if_id_q;
    id_ex_t  ctrl_id, id_ex_d, id_ex_q;
    ex_mem_t ex_mem_d, ex_mem_q;
    mem_wb_t mem_wb_d, mem_wb_q;

    logic [xlen-1:0] pc_if1, pc_if2;
    logic [xlen-1:0] rd1_id, rd2_id;
    logic [xlen-1:0] cmp1, cmp2;
    logic [xlen-1:0] branch_target;
    logic [xlen-1:0] src_a, src_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] wd_wb;
    logic            branch, branch_taken;
    logic            pc_redirect;
    logic            if2_valid;   // low while fetch 2 holds the word read in reset

    hazard_if hz ();

    // a stalled beq sees stale operands, so it only redirects once released
    assign pc_redirect = branch_taken && !hz.stall;

    fetch_unit fetch_inst
    (
        .clk           ( clk           ),
        .reset         ( reset         ),
        .stall         ( hz.stall      ),
        .branch_taken  ( pc_redirect   ),
        .branch_target ( branch_target ),
        .pc_if1        ( pc_if1        ),
        .pc_if2        ( pc_if2        )
    );

    assign instr_addr = pc_if1;

    always_ff @(posedge clk)
    begin
        if (reset)
            if2_valid <= 1'b0;
        else
            if2_valid <= 1'b1;
    end

    assign if_id_d.instr = instr;     // memory answers for pc_if2
    assign if_id_d.pc    = pc_if2;

    pipe_reg #( .payload_t ( if_id_t ) ) if_id_reg
    (
        .clk   ( clk                        ),
        .reset ( reset                      ),
        .en    ( !hz.stall                  ),
        .clr   ( pc_redirect || !if2_valid  ),   // squash the wrong-path slot
        .d     ( if_id_d                    ),
        .q     ( if_id_q                    )
    );

    decode_unit decode_inst
    (
        .instr         ( if_id_q.instr ),
        .pc            ( if_id_q.pc    ),
        .cmp1          ( cmp1          ),
        .cmp2          ( cmp2          ),
        .ctrl          ( ctrl_id       ),
        .branch        ( branch        ),
        .branch_taken  ( branch_taken  ),
        .branch_target ( branch_target )
    );

    reg_file reg_file_inst
    (
        .clk ( clk            ),
        .ra1 ( ctrl_id.ra1    ),
        .ra2 ( ctrl_id.ra2    ),
        .wa3 ( mem_wb_q.wa    ),
        .ra0 ( reg_addr       ),
        .wd3 ( wd_wb          ),
        .we3 ( mem_wb_q.we_rf ),
        .rd1 ( rd1_id         ),
        .rd2 ( rd2_id         ),
        .rd0 ( reg_data       )
    );

    assign cmp1 = (hz.cmp1_bp == bp_mem) ? ex_mem_q.result : rd1_id;
    assign cmp2 = (hz.cmp2_bp == bp_mem) ? ex_mem_q.result : rd2_id;

    always_comb
    begin
        id_ex_d     = ctrl_id;
        id_ex_d.rd1 = rd1_id;
        id_ex_d.rd2 = rd2_id;
    end

    pipe_reg #( .payload_t ( id_ex_t ) ) id_ex_reg
    (
        .clk   ( clk         ),
        .reset ( reset       ),
        .en    ( 1'b1        ),
        .clr   ( hz.flush_ex ),
        .d     ( id_ex_d     ),
        .q     ( id_ex_q     )
    );

    // execute operand bypass, write-back carries the loaded word
    always_comb
    begin
        case (hz.rd1_bp)
            bp_mem:  src_a = ex_mem_q.result;
            bp_wb:   src_a = wd_wb;
            default: src_a = id_ex_q.rd1;
        endcase
        case (hz.rd2_bp)
            bp_mem:  src_b = ex_mem_q.result;
            bp_wb:   src_b = wd_wb;
            default: src_b = id_ex_q.rd2;
        endcase
    end

    exec_unit exec_inst
    (
        .a         ( src_a             ),
        .b         ( src_b             ),
        .imm       ( id_ex_q.imm       ),
        .src_b_imm ( id_ex_q.src_b_imm ),
        .alu_op    ( id_ex_q.alu_op    ),
        .result    ( alu_result        )
    );

    assign ex_mem_d.result     = alu_result;
    assign ex_mem_d.store_data = src_b;          // sw data after bypass
    assign ex_mem_d.wa         = id_ex_q.wa;
    assign ex_mem_d.we_rf      = id_ex_q.we_rf;
    assign ex_mem_d.we_dm      = id_ex_q.we_dm;
    assign ex_mem_d.rf_src     = id_ex_q.rf_src;

    pipe_reg #( .payload_t ( ex_mem_t ) ) ex_mem_reg
    (
        .clk   ( clk      ),
        .reset ( reset    ),
        .en    ( 1'b1     ),
        .clr   ( 1'b0     ),
        .d     ( ex_mem_d ),
        .q     ( ex_mem_q )
    );

    assign addr_dm = ex_mem_q.result;
    assign wd_dm   = ex_mem_q.store_data;
    assign we_dm   = ex_mem_q.we_dm;

    assign mem_wb_d.result = ex_mem_q.result;
    assign mem_wb_d.wa     = ex_mem_q.wa;
    assign mem_wb_d.we_rf  = ex_mem_q.we_rf;
    assign mem_wb_d.rf_src = ex_mem_q.rf_src;

    pipe_reg #( .payload_t ( mem_wb_t ) ) mem_wb_reg
    (
        .clk   ( clk      ),
        .reset ( reset    ),
        .en    ( 1'b1     ),
        .clr   ( 1'b0     ),
        .d     ( mem_wb_d ),
        .q     ( mem_wb_q )
    );

    assign wd_wb = mem_wb_q.rf_src ? rd_dm : mem_wb_q.result;

    // hazard inputs from each stage
    assign hz.ra1_id    = ctrl_id.ra1;
    assign hz.ra2_id    = ctrl_id.ra2;
    assign hz.ra1_ex    = id_ex_q.ra1;
    assign hz.ra2_ex    = id_ex_q.ra2;
    assign hz.wa_ex     = id_ex_q.wa;
    assign hz.wa_mem    = ex_mem_q.wa;
    assign hz.wa_wb     = mem_wb_q.wa;
    assign hz.we_rf_ex  = id_ex_q.we_rf;
    assign hz.we_rf_mem = ex_mem_q.we_rf;
    assign hz.we_rf_wb  = mem_wb_q.we_rf;
    assign hz.load_ex   = id_ex_q.rf_src;
    assign hz.load_mem  = ex_mem_q.rf_src;
    assign hz.branch_id = branch;

    hazard_unit hazard_inst
    (
        .hz ( hz )
    );

endmodule : cpu_core

// File: tests/cpu_core_chk.sv
/* pipeline control checker, bound into the core */
`timescale 1ns/100ps

module cpu_core_chk
(
    input logic                     clk,
    input logic                     reset,
    input logic                     stall,
    input logic [cpu_pkg::xlen-1:0] fetch_addr,
    input logic [cpu_pkg::xlen-1:0] held_addr,
    input logic                     ex_we_rf,
    input logic                     ex_we_dm,
    input logic                     we_dm
);

    // a held beq with stale equal operands must not move the pc
    redirect_not_stalled: assert property (@(posedge clk) disable iff (reset)
        stall |-> fetch_addr == held_addr)
        else $error("fetch redirected while the pipeline is stalled");

    // stage registers are cleared one edge into reset
    no_store_in_reset: assert property (@(posedge clk) $past(reset) |-> !we_dm)
        else $error("data memory write enable high during reset");

    // the stalled slot reaches execute as a bubble
    bubble_on_stall: assert property (@(posedge clk) disable iff (reset)
        stall |=> !ex_we_rf && !ex_we_dm)
        else $error("execute holds a live instruction after a stall");

endmodule : cpu_core_chk

// File: tests/cpu_core_tb.sv
/* testbench for the pipelined core
   memory models, generated program, sequential reference model and result checks */
`timescale 1ns/100ps

module cpu_core_tb;
    import cpu_pkg::*;

    logic        clk;
    logic        reset;
    logic [31:0] instr_addr;
    logic [31:0] instr;
    logic [31:0] addr_dm;
    logic [31:0] wd_dm;
    logic        we_dm;
    logic [31:0] rd_dm;
    logic [4:0]  reg_addr;
    logic [31:0] reg_data;

    logic [31:0] imem [128];
    logic [31:0] dmem [64];
    logic [31:0] mdl_regs [32];
    logic [31:0] exp_addr [$];    // stores in program order
    logic [31:0] exp_data [$];
    logic [15:0] lfsr;
    logic [31:0] end_pc;          // address of the self-loop
    int          prog_len;
    int          store_idx;
    int          n_checks;
    int          errors;
    logic        verdict_done;

    cpu_core cpu_core_inst
    (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .instr_addr ( instr_addr ),
        .instr      ( instr      ),
        .addr_dm    ( addr_dm    ),
        .wd_dm      ( wd_dm      ),
        .we_dm      ( we_dm      ),
        .rd_dm      ( rd_dm      ),
        .reg_addr   ( reg_addr   ),
        .reg_data   ( reg_data   )
    );

    bind cpu_core cpu_core_chk chk_inst
    (
        .clk        ( clk           ),
        .reset      ( reset         ),
        .stall      ( hz.stall      ),
        .fetch_addr ( instr_addr    ),
        .held_addr  ( pc_if2        ),
        .ex_we_rf   ( id_ex_q.we_rf ),
        .ex_we_dm   ( id_ex_q.we_dm ),
        .we_dm      ( we_dm         )
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] draw(input int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [31:0] rs2,
                                           input logic [31:0] rs1, input logic [2:0] f3,
                                           input logic [31:0] rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_op};
    endfunction

    function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [31:0] rs1,
                                           input logic [2:0] f3, input logic [31:0] rd,
                                           input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [31:0] imm, input logic [31:0] rs2,
                                           input logic [31:0] rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [31:0] imm, input logic [31:0] rs2,
                                           input logic [31:0] rs1);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] u_type(input logic [31:0] imm, input logic [31:0] rd);
        return {imm[19:0], rd[4:0], op_lui};
    endfunction

    function automatic void emit(input logic [31:0] w);
        imem[prog_len] = w;
        prog_len++;
    endfunction

    // initial data memory word that differs for every index
    function automatic logic [31:0] fill_word(input int idx);
        return 32'hc0de_0000 ^ (idx * 32'h0103_0507);
    endfunction

    task automatic build_program();
        logic [31:0] ra, rb, rc, rd, re, base, off1, off2;
        int i;
        prog_len = 0;
        for (i = 0; i < 128; i++)
            imem[i] = '0;
        for (i = 1; i < 32; i++)
            emit(i_type(draw(12), 0, 3'b000, i, op_opimm));   // defined start values
        ra   = 1 + draw(3);     // disjoint ranges keep the registers apart
        rb   = 9 + draw(3);
        rc   = 17 + draw(3);
        rd   = 25 + draw(2);
        base = 29 + draw(1);
        re   = 31;
        off1 = draw(3) << 2;
        off2 = draw(3) << 2;
        emit(i_type(draw(4) << 2, 0, 3'b000, base, op_opimm));
        emit(r_type(7'h00, rc, rb, 3'b000, ra));
        emit(r_type(7'h20, rc, ra, 3'b000, rb));    // ra from the memory stage
        emit(r_type(7'h00, rb, ra, 3'b110, rc));    // ra from write-back and rb from memory
        emit(r_type(7'h00, ra, rc, 3'b111, rd));
        emit(u_type(draw(20), re));
        emit(i_type(draw(12), re, 3'b000, re, op_opimm));
        emit(s_type(off1, ra, base));
        emit(i_type(off1, base, 3'b010, rd, op_load));
        emit(r_type(7'h00, rb, rd, 3'b000, ra));    // load-use
        emit(s_type(off2, ra, base));
        emit(r_type(7'h00, rb, ra, 3'b000, rc));
        emit(r_type(7'h00, rb, ra, 3'b000, rd));
        emit(b_type(8, rd, rc));                    // taken while rd is still in execute
        emit(i_type(1, rc, 3'b000, rc, op_opimm));  // wrong path
        emit(b_type(8, 0, ra));
        emit(i_type(draw(12), 0, 3'b000, 0, op_opimm));
        emit(u_type(draw(20), 0));
        emit(r_type(7'h00, rc, 0, 3'b000, rb));     // x0 as operand
        emit(i_type(off2, base, 3'b010, re, op_load));
        emit(b_type(8, ra, re));                    // taken right after a load
        emit(s_type(0, rb, base));                  // wrong path
        emit(s_type(off1, rb, base));
        emit(b_type(8, rc, rb));
        emit(i_type(5, 0, 3'b000, re, op_opimm));   // wrong path
        emit(r_type(7'h00, rb, re, 3'b110, re));
        emit(s_type(off2, re, base));
        end_pc = prog_len * 4;
        emit(b_type(0, 0, 0));
    endtask

    // sequential isa model of the same program
    function automatic void run_model();
        logic [31:0] mem [64];
        logic [31:0] pc, next_pc, w, a, b, addr;
        logic [31:0] imm_i, imm_s, imm_b;
        int i, steps;
        for (i = 0; i < 32; i++)
            mdl_regs[i] = '0;
        for (i = 0; i < 64; i++)
            mem[i] = fill_word(i);
        exp_addr.delete();
        exp_data.delete();
        pc = '0;
        steps = 0;
        w = imem[0];
        while (w != b_type(0, 0, 0) && steps < 1000)
        begin
            a       = mdl_regs[w[19:15]];
            b       = mdl_regs[w[24:20]];
            imm_i   = {{20{w[31]}}, w[31:20]};
            imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            next_pc = pc + 32'd4;
            case (w[6:0])
                op_op:
                    case (w[14:12])
                        3'b000:  mdl_regs[w[11:7]] = w[30] ? a - b : a + b;
                        3'b111:  mdl_regs[w[11:7]] = a & b;
                        3'b110:  mdl_regs[w[11:7]] = a | b;
                        default: ;
                    endcase
                op_opimm: mdl_regs[w[11:7]] = a + imm_i;
                op_lui:   mdl_regs[w[11:7]] = {w[31:12], 12'd0};
                op_load:
                begin
                    addr = a + imm_i;
                    mdl_regs[w[11:7]] = mem[addr[7:2]];
                end
                op_store:
                begin
                    addr = a + imm_s;
                    mem[addr[7:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                op_branch:
                    if (a == b)
                        next_pc = pc + imm_b;
                default: ;
            endcase
            mdl_regs[0] = '0;
            pc = next_pc;
            w = imem[pc[8:2]];
            steps++;
        end
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        n_checks++;
        assert (expected === actual)
        else
        begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // both memories answer one cycle after the address
    initial
    begin : memories
        logic [31:0] if_addr, dm_addr, dm_wd;
        logic        dm_we;
        int i;
        instr = '0;
        rd_dm = '0;
        for (i = 0; i < 64; i++)
            dmem[i] = fill_word(i);
        forever
        begin
            @(negedge clk);
            if_addr = instr_addr;
            dm_addr = addr_dm;
            dm_wd   = wd_dm;
            dm_we   = we_dm;
            @(posedge clk);
            #2;
            instr = imem[if_addr[8:2]];
            if (dm_we)
                dmem[dm_addr[7:2]] = dm_wd;
            rd_dm = dmem[dm_addr[7:2]];
        end
    end

    initial
    begin : store_compare
        store_idx = 0;
        forever
        begin
            @(negedge clk);
            if (reset)
                check("we_dm in reset", 32'd0, {31'd0, we_dm});
            else if (we_dm)
            begin
                if (store_idx < exp_addr.size())
                begin
                    check($sformatf("store %0d address", store_idx), exp_addr[store_idx],
                          addr_dm);
                    check($sformatf("store %0d data", store_idx), exp_data[store_idx], wd_dm);
                end
                else
                begin
                    errors++;
                    $display("store to %h with data %h is more than the program's %0d stores",
                             addr_dm, wd_dm, exp_addr.size());
                end
                store_idx++;
            end
        end
    end

    initial
    begin : main_seq
        int i;
        reset        = 1'b1;
        reg_addr     = '0;
        lfsr         = 16'd75;
        n_checks     = 0;
        errors       = 0;
        verdict_done = 1'b0;
        build_program();
        run_model();
        repeat (2) @(posedge clk);
        @(negedge clk);
        check("instr_addr in reset", 32'd0, instr_addr);
        repeat (2) @(posedge clk);
        #2 reset = 1'b0;
        @(negedge clk);
        check("instr_addr after reset", 32'd0, instr_addr);
        while (instr_addr !== end_pc)
            @(negedge clk);
        repeat (10) @(negedge clk);    // drain the 5 stages plus stalls
        check("store count", exp_addr.size(), store_idx);
        for (i = 0; i < 32; i++)
        begin
            @(posedge clk);
            #2 reg_addr = i[4:0];
            @(negedge clk);
            check($sformatf("register x%0d", i), mdl_regs[i], reg_data);
        end
        $display("checks %0d, errors %0d", n_checks, errors);
        verdict_done = 1'b1;
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin : watchdog
        int limit;
        #1;
        limit = prog_len * 4 + 50;
        repeat (limit) @(posedge clk);
        $display("watchdog: the core did not finish the program within %0d cycles", limit);
        verdict_done = 1'b1;
        $display("CHECKS FAILED");
        $finish;
    end

    // run stopped before a verdict was printed
    final
    begin
        if (!verdict_done)
            $display("CHECKS FAILED");
    end

endmodule : cpu_core_tb

// File: vlog.f
rtl/cpu_pkg.sv
rtl/hazard_if.sv
rtl/pipe_reg.sv
rtl/fetch_unit.sv
rtl/reg_file.sv
rtl/decode_unit.sv
rtl/exec_unit.sv
rtl/hazard_unit.sv
rtl/cpu_core.sv
tests/cpu_core_chk.sv
tests/cpu_core_tb.sv

// File: Makefile
# Verilator build for the pipelined core and its testbench

VERILATOR ?= verilator
TOP       ?= cpu_core_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# the run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
